// ==== tb.f ====
source/ppu_types_pkg.sv
source/ppu_regs_pkg.sv
source/ppu_line_timer.sv
source/ppu_bg_fetcher.sv
source/ppu_pixel_fifo.sv
source/ppu_pixel_mixer.sv
source/ppu_vram.sv
source/ppu_bg_top.sv
test/ppu_bg_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the background PPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ppu_bg_tb -f tb.f -o ppu_bg_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/ppu_bg_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== test/ppu_bg_tb.sv ====
module ppu_bg_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Dot counts of one line and one frame, taken from the DMG timing
  localparam int LINE_CYCLES = 456;
  localparam int FRAME_CYCLES = 154 * LINE_CYCLES;

  logic clk;
  logic reset;
  ppu_regs_pkg::ppu_regs_t regs;
  logic host_we;
  logic [12:0] host_addr;
  logic [7:0] host_wdata;
  ppu_types_pkg::lcd_pixel_t pixel;
  ppu_regs_pkg::ppu_mode_t mode;
  logic [7:0] ly;

  // Mirror of VRAM as the host wrote it, used by the reference model
  logic [7:0] ref_vram [8192];

  integer seed;

  ppu_bg_top #(
    .FIFO_DEPTH (16)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .regs       (regs),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .pixel      (pixel),
    .mode       (mode),
    .ly         (ly)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // All stimulus changes and all sampling happen on the falling edge
  task automatic tick;
    @(negedge clk);
  endtask

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first failed check");
  endtask

  task automatic report_value(input string name, input int got, input int expected);
    string line;
    line = $sformatf("ERR time=%0t %s got=%0d expected=%0d", $time, name, got, expected);
    stop_with_failure(line);
  endtask

  task automatic set_regs(input logic [7:0] lcdc_raw, input logic [7:0] scx,
                          input logic [7:0] scy, input logic [7:0] bgp);
    regs.lcdc.raw = lcdc_raw;
    regs.scx = scx;
    regs.scy = scy;
    regs.bgp = bgp;
  endtask

  // Fills all of VRAM with random bytes through the host port
  task automatic load_vram;
    int a;
    logic [7:0] d;
    for (a = 0; a < 8192; a++) begin
      d = 8'($random(seed));
      host_addr = 13'(a);
      host_wdata = d;
      host_we = 1'b1;
      ref_vram[a] = d;
      tick;
    end
    host_we = 1'b0;
  endtask

  // Reference shade for screen position (x, y) from the background rules
  function automatic logic [1:0] expected_shade(input int x, input int y);
    logic [7:0] mx;
    logic [7:0] my;
    logic [7:0] idx;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [12:0] base;
    logic [12:0] taddr;
    int offset;
    int b;
    int c;
    mx = regs.scx + 8'(x);
    my = regs.scy + 8'(y);
    base = regs.lcdc.flags.bg_map ? 13'h1C00 : 13'h1800;
    idx = ref_vram[base + 13'(my[7:3]) * 13'd32 + 13'(mx[7:3])];
    // Unsigned indexing from 0x0000, or signed indexing around 0x1000
    if (regs.lcdc.flags.tile_data_sel) begin
      offset = int'(idx) * 16;
    end else begin
      offset = 'h1000 + int'($signed(idx)) * 16;
    end
    taddr = 13'(offset + int'(my[2:0]) * 2);
    lo = ref_vram[taddr];
    hi = ref_vram[taddr + 13'd1];
    // Leftmost pixel of a tile is bit 7
    b = 7 - int'(mx[2:0]);
    c = int'({hi[b], lo[b]});
    if (!regs.lcdc.flags.bg_en) begin
      c = 0;
    end
    return {regs.bgp[2 * c + 1], regs.bgp[2 * c]};
  endfunction

  // Returns once ly has just wrapped from 153 to 0
  task automatic wait_frame_start;
    logic [7:0] prev_ly;
    int guard;
    guard = 0;
    prev_ly = ly;
    tick;
    while (!(prev_ly == 8'd153 && ly == 8'd0)) begin
      prev_ly = ly;
      tick;
      guard++;
      if (guard > 2 * FRAME_CYCLES) begin
        stop_with_failure("timeout while waiting for the start of a frame");
      end
    end
  endtask

  // Checks every pixel of the first n_lines lines of the next frame
  task automatic check_lines(input int n_lines);
    int l;
    int count;
    int guard;
    logic [1:0] exp_shade;
    wait_frame_start;
    for (l = 0; l < n_lines; l++) begin
      guard = 0;
      while (!(mode == ppu_regs_pkg::mode_draw && ly == 8'(l))) begin
        assert (!pixel.valid) else stop_with_failure("valid pixel seen outside mode 3");
        tick;
        guard++;
        if (guard > 2 * LINE_CYCLES) begin
          stop_with_failure("timeout while waiting for mode 3 of a line");
        end
      end
      count = 0;
      guard = 0;
      while (mode == ppu_regs_pkg::mode_draw) begin
        if (pixel.valid) begin
          exp_shade = expected_shade(count, l);
          assert (pixel.x == 8'(count)) else report_value("pixel.x", int'(pixel.x), count);
          assert (pixel.y == ly) else report_value("pixel.y", int'(pixel.y), int'(ly));
          assert (pixel.shade == exp_shade)
            else report_value("pixel.shade", int'(pixel.shade), int'(exp_shade));
          count++;
        end
        tick;
        guard++;
        if (guard > LINE_CYCLES) begin
          stop_with_failure("timeout while waiting for mode 3 to end");
        end
      end
      assert (count == 160) else report_value("pixel count", count, 160);
    end
  endtask

  task automatic check_reset;
    int guard;
    assert (!pixel.valid) else report_value("pixel.valid", int'(pixel.valid), 0);
    assert (ly == 8'd0) else report_value("ly", int'(ly), 0);
    assert (mode == ppu_regs_pkg::mode_oam)
      else report_value("mode", int'(mode), int'(ppu_regs_pkg::mode_oam));
    guard = 0;
    while (mode != ppu_regs_pkg::mode_draw) begin
      assert (!pixel.valid) else stop_with_failure("valid pixel before the first mode 3");
      tick;
      guard++;
      if (guard > 2 * LINE_CYCLES) begin
        stop_with_failure("timeout while waiting for the first mode 3 after reset");
      end
    end
  endtask

  task automatic test_unsigned_map0;
    set_regs(8'h91, 8'd0, 8'd0, 8'hE4);
    load_vram;
    check_lines(6);
  endtask

  task automatic test_signed_map1;
    int i;
    bit found;
    set_regs(8'h89, 8'd0, 8'd0, 8'hE4);
    load_vram;
    found = 1'b0;
    // Without scroll only map columns 0 to 19 of row 0 reach the screen
    for (i = 0; i < 20; i++) begin
      if (ref_vram[13'h1C00 + 13'(i)] >= 8'd128) begin
        found = 1'b1;
      end
    end
    assert (found) else stop_with_failure("visible map row 0 holds no tile index of 128 or above");
    check_lines(8);
  endtask

  task automatic test_scroll;
    // Fine discard of 5, coarse column 1 and rows 250 to 259 across the 256 row wrap
    set_regs(8'h91, 8'd13, 8'd250, 8'hE4);
    load_vram;
    check_lines(10);
    // Columns 25 to 45 cross the 32 column wrap of the map
    set_regs(8'h91, 8'd205, 8'd250, 8'hE4);
    load_vram;
    check_lines(8);
  endtask

  task automatic test_palette;
    // Reversed palette maps color c to shade 3 - c
    set_regs(8'h91, 8'd0, 8'd0, 8'h1B);
    load_vram;
    check_lines(3);
    // Background off, every pixel takes palette entry 0
    set_regs(8'h90, 8'd0, 8'd0, 8'h1B);
    check_lines(2);
  endtask

  function automatic bit legal_transition(input ppu_regs_pkg::ppu_mode_t prev_m,
                                          input ppu_regs_pkg::ppu_mode_t next_m);
    case (prev_m)
      ppu_regs_pkg::mode_oam: return next_m == ppu_regs_pkg::mode_draw;
      ppu_regs_pkg::mode_draw: return next_m == ppu_regs_pkg::mode_hblank;
      ppu_regs_pkg::mode_hblank:
        return (next_m == ppu_regs_pkg::mode_oam) || (next_m == ppu_regs_pkg::mode_vblank);
      default: return next_m == ppu_regs_pkg::mode_oam;
    endcase
  endfunction

  // Watches one whole frame plus one line, a length fixed by the line timing
  task automatic test_frame_structure;
    ppu_regs_pkg::ppu_mode_t prev_mode;
    logic [7:0] prev_ly;
    logic [7:0] exp_ly;
    int cycle;
    int last_oam;
    int gap;
    bit saw_last_line;
    bit wrapped;
    saw_last_line = 1'b0;
    wrapped = 1'b0;
    last_oam = 0;
    wait_frame_start;
    prev_mode = mode;
    prev_ly = ly;
    for (cycle = 1; cycle <= FRAME_CYCLES + LINE_CYCLES; cycle++) begin
      tick;
      if (mode != prev_mode) begin
        assert (legal_transition(prev_mode, mode))
          else stop_with_failure($sformatf("illegal mode change from %0d to %0d on line %0d",
                                           int'(prev_mode), int'(mode), int'(ly)));
        if (mode == ppu_regs_pkg::mode_oam) begin
          // Line 0 follows ten blank lines after the scan of line 143
          gap = (ly == 8'd0) ? 11 * LINE_CYCLES : LINE_CYCLES;
          assert (cycle - last_oam == gap)
            else report_value("mode_oam entry spacing", cycle - last_oam, gap);
          last_oam = cycle;
        end
      end
      if (ly != prev_ly) begin
        exp_ly = (prev_ly == 8'd153) ? 8'd0 : prev_ly + 8'd1;
        assert (ly == exp_ly) else report_value("ly", int'(ly), int'(exp_ly));
        if (ly == 8'd153) begin
          saw_last_line = 1'b1;
        end
        if (prev_ly == 8'd153) begin
          wrapped = 1'b1;
        end
      end
      assert ((mode == ppu_regs_pkg::mode_vblank) == (ly >= 8'd144))
        else stop_with_failure($sformatf("mode %0d does not fit line %0d", int'(mode), int'(ly)));
      if (ly >= 8'd144) begin
        assert (!pixel.valid) else stop_with_failure("valid pixel during vertical blank");
      end
      prev_mode = mode;
      prev_ly = ly;
    end
    assert (saw_last_line && wrapped) else stop_with_failure("ly did not reach 153 and wrap to 0");
  endtask

  initial begin
    seed = 32'h8bf5b6c7;
    reset = 1'b1;
    host_we = 1'b0;
    host_addr = 13'd0;
    host_wdata = 8'd0;
    regs = '0;
    set_regs(8'h91, 8'd0, 8'd0, 8'hE4);
    repeat (16) tick;
    reset = 1'b0;
    check_reset;
    test_unsigned_map0;
    test_signed_map1;
    test_scroll;
    test_palette;
    test_frame_structure;
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== source/ppu_bg_top.sv ====
module ppu_bg_top #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  ppu_regs_pkg::ppu_regs_t   regs,
  input  logic                      host_we,
  input  logic [12:0]               host_addr,
  input  logic [7:0]                host_wdata,
  output ppu_types_pkg::lcd_pixel_t pixel,
  output ppu_regs_pkg::ppu_mode_t   mode,
  output logic [7:0]                ly
);

  logic [8:0] dot;
  logic line_start;
  logic line_done;

  ppu_types_pkg::vram_wb_req_t wb_req;
  ppu_types_pkg::vram_wb_rsp_t wb_rsp;

  logic push;
  logic pop;
  logic fifo_empty;
  ppu_types_pkg::pixel_t push_data;
  ppu_types_pkg::pixel_t pop_data;

  // Line and frame sequencing, mode 3 closed by the mixer
  ppu_line_timer u_timer (
    .clk        (clk),
    .reset      (reset),
    .line_done  (line_done),
    .mode       (mode),
    .ly         (ly),
    .dot        (dot),
    .line_start (line_start)
  );

  // Tile fetcher, flushed at the start of every visible line
  ppu_bg_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .flush      (line_start),
    .mode       (mode),
    .dot        (dot),
    .ly         (ly),
    .regs       (regs),
    .wb_rsp     (wb_rsp),
    .fifo_empty (fifo_empty),
    .wb_req     (wb_req),
    .push       (push),
    .push_data  (push_data)
  );

  ppu_pixel_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .reset     (reset),
    .flush     (line_start),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (fifo_empty)
  );

  ppu_pixel_mixer u_mixer (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .ly         (ly),
    .regs       (regs),
    .fifo_empty (fifo_empty),
    .pop_data   (pop_data),
    .pop        (pop),
    .pixel      (pixel),
    .line_done  (line_done)
  );

  // Video RAM shared by the host write port and the fetcher
  ppu_vram u_vram (
    .clk        (clk),
    .reset      (reset),
    .wb_req     (wb_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .wb_rsp     (wb_rsp)
  );

endmodule

// ==== source/ppu_vram.sv ====
module ppu_vram (
  input  logic                        clk,
  input  logic                        reset,
  input  ppu_types_pkg::vram_wb_req_t wb_req,
  input  logic                        host_we,
  input  logic [12:0]                 host_addr,
  input  logic [7:0]                  host_wdata,
  output ppu_types_pkg::vram_wb_rsp_t wb_rsp
);

  logic [7:0] mem [8192];

  logic ack;
  logic [7:0] rdata;
  logic req;

  assign req = wb_req.cyc && wb_req.stb;

  // Ack comes one cycle after the strobe is first seen
  // Blocking on the current ack keeps a held strobe from being answered twice
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= req && !ack;
    end
  end

  // Host writes go straight in, any cycle
  // A read of the same address in the same cycle still sees the old byte
  always_ff @(posedge clk) begin
    if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
    if (req) begin
      rdata <= mem[wb_req.adr];
    end
  end

  assign wb_rsp = '{ack: ack, dat: rdata};

endmodule

// ==== source/ppu_pixel_mixer.sv ====
module ppu_pixel_mixer (
  input  logic                      clk,
  input  logic                      reset,
  input  ppu_regs_pkg::ppu_mode_t   mode,
  input  logic [7:0]                ly,
  input  ppu_regs_pkg::ppu_regs_t   regs,
  input  logic                      fifo_empty,
  input  ppu_types_pkg::pixel_t     pop_data,
  output logic                      pop,
  output ppu_types_pkg::lcd_pixel_t pixel,
  output logic                      line_done
);

  // Pixels already taken on this line
  logic [7:0] x_count;

  logic drawing;
  logic last_pixel;
  ppu_types_pkg::gb_color_t color;

  assign drawing = (mode == ppu_regs_pkg::mode_draw);

  // Stop at the screen width even if the fetcher keeps filling the FIFO
  assign pop = drawing && !fifo_empty && (x_count < 8'(ppu_regs_pkg::SCREEN_W));

  assign last_pixel = (x_count == 8'(ppu_regs_pkg::SCREEN_W - 1));

  // With the background disabled every pixel shows palette entry 0
  assign color = regs.lcdc.flags.bg_en ? pop_data.color : 2'd0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_count <= 8'd0;
    end else if (!drawing) begin
      x_count <= 8'd0;
    end else if (pop) begin
      x_count <= x_count + 8'd1;
    end
  end

  // Output stage, one cycle behind the pop
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pixel     <= '0;
      line_done <= 1'b0;
    end else begin
      pixel.valid <= pop && pop_data.valid;
      pixel.x     <= x_count;
      pixel.y     <= ly;
      // BGP holds two shade bits per color, color 0 in the low pair
      pixel.shade <= {regs.bgp[{color, 1'b1}], regs.bgp[{color, 1'b0}]};
      line_done   <= pop && last_pixel;
    end
  end

endmodule

// ==== source/ppu_pixel_fifo.sv ====
module ppu_pixel_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  push,
  input  ppu_types_pkg::pixel_t push_data,
  input  logic                  pop,
  output ppu_types_pkg::pixel_t pop_data,
  output logic                  empty
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  ppu_types_pkg::pixel_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic do_push;
  logic do_pop;

  assign empty = (count == CNT_W'(0));

  // Guard both ends so a stray request cannot corrupt the count
  assign do_push = push && (count != CNT_W'(FIFO_DEPTH));
  assign do_pop = pop && !empty;

  // Head of the queue is visible without a read cycle
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // Leftover pixels from the previous line are dropped
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      // Simultaneous push and pop leave the count unchanged
      if (do_push && !do_pop) begin
        count <= count + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// ==== source/ppu_bg_fetcher.sv ====
module ppu_bg_fetcher (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        flush,
  input  ppu_regs_pkg::ppu_mode_t     mode,
  input  logic [8:0]                  dot,
  input  logic [7:0]                  ly,
  input  ppu_regs_pkg::ppu_regs_t     regs,
  input  ppu_types_pkg::vram_wb_rsp_t wb_rsp,
  input  logic                        fifo_empty,
  output ppu_types_pkg::vram_wb_req_t wb_req,
  output logic                        push,
  output ppu_types_pkg::pixel_t       push_data
);

  typedef enum logic [2:0] {
    st_get_tile,
    st_get_low,
    st_get_high,
    st_sleep,
    st_push
  } fetch_state_t;

  fetch_state_t state;

  // Map column of the tile being fetched
  // It is loaded with SCX/8, so it always holds (SCX/8 + column) mod 32
  logic [4:0] map_col;

  // Pixels still to be dropped at the start of the line for fine scroll
  logic [2:0] discard;

  // Position inside the tile row during the push phase
  logic [2:0] push_i;

  // Second cycle of the sleep phase
  logic sleep_cnt;

  // Tile number and the two bit planes of the current row
  logic [7:0] tile_index;
  logic [7:0] tile_low;
  logic [7:0] tile_high;

  logic drawing;
  logic load_line;
  logic reading;
  logic push_cycle;
  logic [7:0] map_y;
  logic [12:0] map_base;
  logic [12:0] map_addr;
  logic [12:0] row_addr;
  logic [12:0] read_addr;
  logic [2:0] bit_sel;

  assign drawing = (mode == ppu_regs_pkg::mode_draw);

  // Last OAM scan dot, one cycle before drawing starts
  assign load_line = (mode == ppu_regs_pkg::mode_oam) &&
                     (dot == 9'(ppu_regs_pkg::MODE2_LEN - 1));

  // Background row in the 256 line map, wrapping naturally in 8 bits
  assign map_y = regs.scy + ly;

  assign map_base = regs.lcdc.flags.bg_map ? 13'h1C00 : 13'h1800;

  // Each map row holds 32 tile numbers
  assign map_addr = map_base + {3'b000, map_y[7:3], map_col};

  // Tile data row address, 16 bytes per tile and 2 bytes per row
  // In signed mode the base is 0x1000 and indices 128 to 255 land in 0x0800 to 0x0FFF,
  // which is the unsigned layout with bit 12 set only for indices below 128
  assign row_addr = {~regs.lcdc.flags.tile_data_sel & ~tile_index[7], tile_index,
                     map_y[2:0], 1'b0};

  always_comb begin
    case (state)
      st_get_low: read_addr = row_addr;
      st_get_high: read_addr = row_addr | 13'd1;
      default: read_addr = map_addr;
    endcase
  end

  // The request stays up in a read state until ack, so each read is two cycles
  assign reading = drawing && ((state == st_get_tile) || (state == st_get_low) ||
                               (state == st_get_high));

  assign wb_req = '{cyc: reading, stb: reading, adr: read_addr};

  // A tile row may only start into an empty FIFO, then it runs for 8 cycles
  assign push_cycle = drawing && (state == st_push) && ((push_i != 3'd0) || fifo_empty);

  // Discarded pixels still take their cycle but never reach the FIFO
  assign push = push_cycle && (discard == 3'd0);

  // Leftmost pixel is bit 7 of both planes
  assign bit_sel = 3'd7 - push_i;

  // High plane gives the upper color bit
  assign push_data = '{color: {tile_high[bit_sel], tile_low[bit_sel]}, valid: 1'b1};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= st_get_tile;
      map_col   <= 5'd0;
      discard   <= 3'd0;
      push_i    <= 3'd0;
      sleep_cnt <= 1'b0;
    end else if (flush) begin
      state     <= st_get_tile;
      push_i    <= 3'd0;
      sleep_cnt <= 1'b0;
    end else if (load_line) begin
      // Coarse and fine scroll are taken once per line
      map_col <= regs.scx[7:3];
      discard <= regs.scx[2:0];
    end else if (drawing) begin
      case (state)
        st_get_tile: begin
          if (wb_rsp.ack) begin
            state <= st_get_low;
          end
        end
        st_get_low: begin
          if (wb_rsp.ack) begin
            state <= st_get_high;
          end
        end
        st_get_high: begin
          if (wb_rsp.ack) begin
            state <= st_sleep;
          end
        end
        st_sleep: begin
          sleep_cnt <= ~sleep_cnt;
          if (sleep_cnt) begin
            state <= st_push;
          end
        end
        st_push: begin
          if (push_cycle) begin
            push_i <= push_i + 3'd1;
            if (discard != 3'd0) begin
              discard <= discard - 3'd1;
            end
            // Row complete, move one tile right in the map
            if (push_i == 3'd7) begin
              state   <= st_get_tile;
              map_col <= map_col + 5'd1;
            end
          end
        end
        default: begin
          state <= st_get_tile;
        end
      endcase
    end
  end

  // Read data is captured on the ack that ends each read
  always_ff @(posedge clk) begin
    if (drawing && wb_rsp.ack) begin
      case (state)
        st_get_tile: tile_index <= wb_rsp.dat;
        st_get_low: tile_low <= wb_rsp.dat;
        st_get_high: tile_high <= wb_rsp.dat;
        default: tile_index <= tile_index;
      endcase
    end
  end

endmodule

// ==== source/ppu_line_timer.sv ====
module ppu_line_timer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    line_done,
  output ppu_regs_pkg::ppu_mode_t mode,
  output logic [7:0]              ly,
  output logic [8:0]              dot,
  output logic                    line_start
);

  logic last_dot;
  logic [7:0] next_ly;

  // The final dot of a line closes it whatever mode is active
  assign last_dot = (dot == 9'(ppu_regs_pkg::LINE_DOTS - 1));

  // Line counter wraps from the last vertical blank line back to line 0
  assign next_ly = (ly == 8'(ppu_regs_pkg::FRAME_LINES - 1)) ? 8'd0 : ly + 8'd1;

  // Flush pulse for the fetch path, only on lines that will be drawn
  assign line_start = (dot == 9'd0) && (ly < 8'(ppu_regs_pkg::VISIBLE_LINES));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot  <= 9'd0;
      ly   <= 8'd0;
      mode <= ppu_regs_pkg::mode_oam;
    end else if (last_dot) begin
      dot <= 9'd0;
      ly  <= next_ly;
      // A new line opens with OAM scan when visible, otherwise it is blanking
      if (next_ly < 8'(ppu_regs_pkg::VISIBLE_LINES)) begin
        mode <= ppu_regs_pkg::mode_oam;
      end else begin
        mode <= ppu_regs_pkg::mode_vblank;
      end
    end else begin
      dot <= dot + 9'd1;
      case (mode)
        ppu_regs_pkg::mode_oam: begin
          // Drawing begins on dot 80, right after the scan window
          if (dot == 9'(ppu_regs_pkg::MODE2_LEN - 1)) begin
            mode <= ppu_regs_pkg::mode_draw;
          end
        end
        ppu_regs_pkg::mode_draw: begin
          // Drawing length depends on the fine scroll, so the mixer ends it
          if (line_done) begin
            mode <= ppu_regs_pkg::mode_hblank;
          end
        end
        default: begin
          // HBlank and VBlank hold until the line ends
          mode <= mode;
        end
      endcase
    end
  end

endmodule

// ==== source/ppu_regs_pkg.sv ====
package ppu_regs_pkg;

  // LCDC bit assignment, bit 7 first
  // Only tile_data_sel, bg_map and bg_en steer this background-only design
  typedef struct packed {
    logic lcd_en;
    logic win_map;
    logic win_en;
    logic tile_data_sel;
    logic bg_map;
    logic obj_size;
    logic obj_en;
    logic bg_en;
  } lcdc_flags_t;

  // The host writes LCDC as a plain byte while the RTL reads the flags
  typedef union packed {
    logic [7:0]  raw;
    lcdc_flags_t flags;
  } lcdc_t;

  // Register block seen by the PPU, held static by the host
  typedef struct packed {
    lcdc_t      lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
    logic [7:0] bgp;
  } ppu_regs_t;

  // Encoding follows the STAT mode field
  typedef enum logic [1:0] {
    mode_hblank = 2'd0,
    mode_vblank = 2'd1,
    mode_oam    = 2'd2,
    mode_draw   = 2'd3
  } ppu_mode_t;

  // Length of the OAM scan phase at the start of each visible line
  localparam int MODE2_LEN = 80;

  // Dots per line and lines per frame, including the vertical blank
  localparam int LINE_DOTS = 456;
  localparam int VISIBLE_LINES = 144;
  localparam int FRAME_LINES = 154;

  // Visible pixels per line
  localparam int SCREEN_W = 160;

endpackage

// ==== source/ppu_types_pkg.sv ====
package ppu_types_pkg;

  // Raw two-bit color index as stored in tile data, before the palette
  typedef logic [1:0] gb_color_t;

  // One entry of the background pixel FIFO
  typedef struct packed {
    gb_color_t color;
    logic      valid;
  } pixel_t;

  // Request side of the VRAM Wishbone classic bus
  // The address is a byte offset into the 8 KiB VRAM, not a CPU address
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [12:0] adr;
  } vram_wb_req_t;

  // Response side of the VRAM bus
  // Data is only meaningful in the cycle where ack is high
  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } vram_wb_rsp_t;

  // Shaded pixel as it leaves the PPU toward the LCD
  // The coordinates let a consumer place it without counting itself
  typedef struct packed {
    logic       valid;
    logic [7:0] x;
    logic [7:0] y;
    logic [1:0] shade;
  } lcd_pixel_t;

endpackage
